// ==== include/scope_params.svh ====
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

////////////////////
// Screen geometry
`define H_ACTIVE    800
`define HIST_DEPTH  1024
`define HIST_AW     10
`define COUNT_W     10

// Sample and trace widths
`define SAMPLE_W    12
`define TRACE_W     8
`define NUM_CH      4

////////////////////
// Trace layout, bands stack downwards from the first trace row
`define TRACE_TOP   224
`define BAND_STEP   32

// Vertical line where low x bits are all ones, horizontal where low y bits are zero
`define GRID_X_MASK 10'h03F
`define GRID_Y_MASK 10'h01F

// Address, memory read, colour mix
`define PIPE_LAT    3

////////////////////
// Colours
`define COL_CH0     24'hFFFFFF
`define COL_CH1     24'hFF0000
`define COL_CH2     24'h00FF00
`define COL_CH3     24'h0000FF
`define COL_GRID    24'h808080

`endif

// ==== design/scope_pkg.sv ====
`default_nettype none

`include "scope_params.svh"

package scope_pkg;

	// One sample word per channel, channel 0 in the low bits
	typedef struct packed {
		logic [`NUM_CH-1:0][`SAMPLE_W-1:0] ch;
	} sample_set_t;

	// Stored column entry, upper bits of the frame extremes
	typedef struct packed {
		logic [`TRACE_W-1:0] min_val;
		logic [`TRACE_W-1:0] max_val;
	} span_t;

	// Pixel position and flags, aligned with the history read data
	// The read address runs one pixel ahead of the other fields
	typedef struct packed {
		logic [`COUNT_W-1:0] x;
		logic [`COUNT_W-1:0] y;
		logic [`HIST_AW-1:0] raddr;
		logic in_win;
		logic grid;
	} scan_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

endpackage

`default_nettype wire

// ==== design/scan_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module scan_timing (
	input logic clk,
	input logic reset,
	input logic blank,
	input logic vsync,
	output logic frame_start,
	output logic hist_we,
	output logic [`HIST_AW-1:0] hist_waddr,
	output scope_pkg::scan_t scan
);

	// Newest column sits at the right edge of the screen
	localparam logic [`HIST_AW-1:0] RD_BACK = `HIST_AW'(`H_ACTIVE - 1);
	localparam logic [`COUNT_W-1:0] WIN_TOP = `COUNT_W'(`TRACE_TOP);

	logic vsync_d;
	logic blank_d;
	logic [`COUNT_W-1:0] x_cnt;
	logic [`COUNT_W-1:0] y_cnt;

	// Stage one, in step with the read address
	logic [`HIST_AW-1:0] rd_addr;
	logic [`COUNT_W-1:0] x_p1;
	logic [`COUNT_W-1:0] y_p1;
	logic win_p1;
	logic grid_p1;

	// Stage two, in step with the memory output
	logic [`COUNT_W-1:0] x_p2;
	logic [`COUNT_W-1:0] y_p2;
	logic win_p2;
	logic grid_p2;

	////////////////////
	// Frame events and history write address
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d <= 1'b0;
			frame_start <= 1'b0;
			hist_we <= 1'b0;
			hist_waddr <= RD_BACK;
		end else begin
			vsync_d <= vsync;
			frame_start <= vsync && !vsync_d;
			hist_we <= !vsync && vsync_d;
			// Address moves with the write strobe, wraps at the memory depth
			if (!vsync && vsync_d) begin
				hist_waddr <= hist_waddr + 1'b1;
			end
		end
	end

	////////////////////
	// Pixel and line counters
	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			blank_d <= blank;
			x_cnt <= blank ? '0 : x_cnt + 1'b1;
			if (vsync) begin
				y_cnt <= '0;
			end else if (blank && !blank_d) begin
				y_cnt <= y_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Scrolling read address and delayed pixel flags
	always_ff @(posedge clk) begin
		rd_addr <= hist_waddr - RD_BACK + x_cnt;
		x_p1 <= x_cnt;
		y_p1 <= y_cnt;
		win_p1 <= y_cnt >= WIN_TOP;
		grid_p1 <= ((x_cnt & `GRID_X_MASK) == `GRID_X_MASK) || ((y_cnt & `GRID_Y_MASK) == '0);
		x_p2 <= x_p1;
		y_p2 <= y_p1;
		win_p2 <= win_p1;
		grid_p2 <= grid_p1;
	end

	assign scan = '{x: x_p2, y: y_p2, raddr: rd_addr, in_win: win_p2, grid: grid_p2};

	// A frame never closes in the cycle the next one opens
	assert property (@(posedge clk) disable iff (reset) !(hist_we && frame_start));

endmodule

`default_nettype wire

// ==== design/channel_trace.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module channel_trace #(
	parameter int CH_INDEX = 0
) (
	input logic clk,
	input logic reset,
	input logic ad_strobe,
	input logic [`SAMPLE_W-1:0] sample,
	input logic frame_start,
	input logic hist_we,
	input logic [`HIST_AW-1:0] hist_waddr,
	input scope_pkg::scan_t scan,
	output logic hit
);

	import scope_pkg::*;

	// First row of this channel's band
	localparam logic [`COUNT_W-1:0] BAND_BASE = `COUNT_W'(`TRACE_TOP + CH_INDEX * `BAND_STEP);

	logic [`SAMPLE_W-1:0] run_min;
	logic [`SAMPLE_W-1:0] run_max;
	logic run_empty;
	logic [`SAMPLE_W-1:0] held_min;
	logic [`SAMPLE_W-1:0] held_max;
	logic held_valid;

	span_t hist_mem [`HIST_DEPTH];
	span_t rd_span;
	logic [`COUNT_W-1:0] row;

	////////////////////
	// Span bookkeeping
	always_ff @(posedge clk) begin
		if (reset) begin
			run_empty <= 1'b1;
			held_valid <= 1'b0;
		end else begin
			// A strobe in the frame start cycle already opens the new span
			if (ad_strobe) begin
				run_empty <= 1'b0;
			end else if (frame_start) begin
				run_empty <= 1'b1;
			end
			if (frame_start && !run_empty) begin
				held_valid <= 1'b1;
			end
		end
	end

	// Running min/max over the frame
	always_ff @(posedge clk) begin
		if (ad_strobe) begin
			if (run_empty || frame_start) begin
				run_min <= sample;
				run_max <= sample;
			end else begin
				if (sample < run_min) begin
					run_min <= sample;
				end
				if (sample > run_max) begin
					run_max <= sample;
				end
			end
		end
		// Held span is what the next vsync end stores
		if (frame_start) begin
			held_min <= run_min;
			held_max <= run_max;
		end
	end

	////////////////////
	// History memory, one column per frame
	always_ff @(posedge clk) begin
		if (hist_we) begin
			hist_mem[hist_waddr] <= '{
				min_val: held_min[`SAMPLE_W-1 -: `TRACE_W],
				max_val: held_max[`SAMPLE_W-1 -: `TRACE_W]
			};
		end
		rd_span <= hist_mem[scan.raddr];
	end

	////////////////////
	// Bar hit test against the row inside the band
	assign row = scan.y - BAND_BASE;

	assign hit = scan.in_win && (scan.y >= BAND_BASE)
		&& (row >= `COUNT_W'(rd_span.min_val))
		&& (row <= `COUNT_W'(rd_span.max_val));

	// Extremes stay ordered across every strobe and frame handover
	assert property (@(posedge clk) disable iff (reset) held_valid |-> held_min <= held_max);

endmodule

`default_nettype wire

// ==== design/pixel_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module pixel_mixer (
	input logic clk,
	input logic reset,
	input logic [`NUM_CH-1:0] hits,
	input scope_pkg::scan_t scan,
	output scope_pkg::rgb_t rgb
);

	////////////////////
	// Fixed priority with the lower channel on top and the grid underneath
	always_ff @(posedge clk) begin
		if (reset) begin
			rgb <= '0;
		end else if (hits[0]) begin
			rgb <= `COL_CH0;
		end else if (hits[1]) begin
			rgb <= `COL_CH1;
		end else if (hits[2]) begin
			rgb <= `COL_CH2;
		end else if (hits[3]) begin
			rgb <= `COL_CH3;
		end else if (scan.in_win && scan.grid) begin
			rgb <= `COL_GRID;
		end else begin
			rgb <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== design/vga_scope.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module vga_scope (
	input logic clk,
	input logic reset,
	input logic blank,
	input logic vsync,
	input logic ad_strobe,
	input scope_pkg::sample_set_t samples,
	output scope_pkg::rgb_t rgb
);

	import scope_pkg::*;

	logic frame_start;
	logic hist_we;
	logic [`HIST_AW-1:0] hist_waddr;
	scan_t scan;
	logic [`NUM_CH-1:0] hits;

	////////////////////
	// Video timing and history addressing
	scan_timing u_scan_timing (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.frame_start(frame_start),
		.hist_we(hist_we),
		.hist_waddr(hist_waddr),
		.scan(scan)
	);

	////////////////////
	// One trace per channel, each in its own band
	genvar gi;
	generate
		for (gi = 0; gi < `NUM_CH; gi++) begin : g_ch
			channel_trace #(
				.CH_INDEX(gi)
			) u_channel_trace (
				.clk(clk),
				.reset(reset),
				.ad_strobe(ad_strobe),
				.sample(samples.ch[gi]),
				.frame_start(frame_start),
				.hist_we(hist_we),
				.hist_waddr(hist_waddr),
				.scan(scan),
				.hit(hits[gi])
			);
		end
	endgenerate

	// Colour out
	pixel_mixer u_pixel_mixer (
		.clk(clk),
		.reset(reset),
		.hits(hits),
		.scan(scan),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== verification/vga_scope_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module vga_scope_tb;

	import scope_pkg::*;

	localparam int LINE_BLANK = 160;
	localparam int ROWS_ACTIVE = 480;
	localparam int ROWS_TOTAL = 525;
	localparam int VS_FIRST = 490;
	localparam int VS_LAST = 491;
	localparam int NUM_FRAMES = 6;
	localparam int RESET_CYCLES = 10;
	localparam int unsigned FRAME_CYCLES = (`H_ACTIVE + LINE_BLANK) * ROWS_TOTAL;
	localparam int unsigned MAX_CYCLES = (NUM_FRAMES + 1) * FRAME_CYCLES + RESET_CYCLES;

	// One displayed column with channel 0 in the low bits
	typedef span_t [`NUM_CH-1:0] column_t;

	typedef struct packed {
		int unsigned tag;
		int x;
		int y;
		rgb_t colour;
	} pixel_rec_t;

	logic clk = 1'b0;
	logic reset;
	logic blank;
	logic vsync;
	logic ad_strobe;
	sample_set_t samples;
	rgb_t rgb;

	int unsigned cycle_count = 0;
	int unsigned error_count = 0;
	int unsigned check_count = 0;

	// Reference state with the newest column at the front of the history
	column_t history [$];
	pixel_rec_t pending [$];
	pixel_rec_t seen_rec;
	int unsigned band_lo [`NUM_CH];
	int unsigned band_span [`NUM_CH];
	int unsigned frame_min [`NUM_CH];
	int unsigned frame_max [`NUM_CH];
	logic [`NUM_CH-1:0] frame_seen;

	vga_scope u_vga_scope (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.ad_strobe(ad_strobe),
		.samples(samples),
		.rgb(rgb)
	);

	always #50 clk = ~clk;

	////////////////////
	// Reference model
	function automatic rgb_t channel_colour(input int ch);
		case (ch)
			0: return `COL_CH0;
			1: return `COL_CH1;
			2: return `COL_CH2;
			default: return `COL_CH3;
		endcase
	endfunction

	function automatic rgb_t expected_colour(input int x, input int y, input column_t shown);
		int ch;
		int row;
		rgb_t colour;
		colour = '0;
		if (y >= `TRACE_TOP) begin
			if ((x % 64 == 63) || (y % 32 == 0)) begin
				colour = `COL_GRID;
			end
			// Walk from the last channel so the lowest one ends on top
			for (ch = `NUM_CH - 1; ch >= 0; ch--) begin
				row = y - (`TRACE_TOP + ch * `BAND_STEP);
				if (row >= 0 && row >= int'(shown[ch].min_val)
						&& row <= int'(shown[ch].max_val)) begin
					colour = channel_colour(ch);
				end
			end
		end
		return colour;
	endfunction

	////////////////////
	// Stimulus
	task automatic pick_bands();
		int ch;
		for (ch = 0; ch < `NUM_CH; ch++) begin
			band_lo[ch] = $urandom_range(3500, 0);
			band_span[ch] = $urandom_range(595, 0);
		end
	endtask

	task automatic close_frame();
		int ch;
		column_t newest;
		for (ch = 0; ch < `NUM_CH; ch++) begin
			newest[ch].min_val = `TRACE_W'(frame_min[ch] >> (`SAMPLE_W - `TRACE_W));
			newest[ch].max_val = `TRACE_W'(frame_max[ch] >> (`SAMPLE_W - `TRACE_W));
		end
		frame_seen = '0;
		history.push_front(newest);
	endtask

	task automatic drive_pixel(input int line, input int col);
		int ch;
		int age;
		int unsigned value;
		pixel_rec_t rec;
		blank = !(line < ROWS_ACTIVE && col < `H_ACTIVE);
		ad_strobe = 1'b0;
		if (!blank) begin
			// First pixel of every frame strobes, so no span stays empty
			if ((line == 0 && col == 0) || $urandom_range(15, 0) == 0) begin
				ad_strobe = 1'b1;
				for (ch = 0; ch < `NUM_CH; ch++) begin
					value = band_lo[ch] + $urandom_range(band_span[ch], 0);
					samples.ch[ch] = `SAMPLE_W'(value);
					if (!frame_seen[ch] || value < frame_min[ch]) begin
						frame_min[ch] = value;
					end
					if (!frame_seen[ch] || value > frame_max[ch]) begin
						frame_max[ch] = value;
					end
					frame_seen[ch] = 1'b1;
				end
			end
			age = `H_ACTIVE - 1 - col;
			if (line < `TRACE_TOP || age < history.size()) begin
				rec.tag = cycle_count;
				rec.x = col;
				rec.y = line;
				rec.colour = expected_colour(col, line,
					(age < history.size()) ? history[age] : '0);
				pending.push_back(rec);
			end
		end
	endtask

	task automatic run_frame();
		int line;
		int col;
		pick_bands();
		for (line = 0; line < ROWS_TOTAL; line++) begin
			vsync = (line >= VS_FIRST) && (line <= VS_LAST);
			// The closed frame lands in history once vsync ends
			if (line == VS_LAST + 1) begin
				close_frame();
			end
			for (col = 0; col < `H_ACTIVE + LINE_BLANK; col++) begin
				drive_pixel(line, col);
				@(negedge clk);
			end
		end
	endtask

	////////////////////
	// Cycle count and timeout
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	// Compare rgb against the pixel driven PIPE_LAT cycles earlier
	always @(negedge clk) begin
		if (pending.size() > 0 && pending[0].tag + `PIPE_LAT == cycle_count) begin
			seen_rec = pending.pop_front();
			check_count++;
			if (rgb !== seen_rec.colour) begin
				error_count++;
				$display("FAILED t=%0t rgb x=%0d y=%0d expected %06h got %06h",
					$time, seen_rec.x, seen_rec.y, seen_rec.colour, rgb);
			end
		end
	end

	initial begin
		int frame;
		void'($urandom(32'h9400_3902));
		reset = 1'b1;
		blank = 1'b1;
		vsync = 1'b0;
		ad_strobe = 1'b0;
		samples = '0;
		frame_seen = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		if (rgb !== '0) begin
			error_count++;
			$display("FAILED t=%0t rgb in reset expected 000000 got %06h", $time, rgb);
		end
		reset = 1'b0;
		for (frame = 0; frame < NUM_FRAMES; frame++) begin
			run_frame();
		end
		if (pending.size() != 0) begin
			error_count++;
			$display("Some expected pixels were never compared: %0d left", pending.size());
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vga_scope.f ====
+incdir+include
design/scope_pkg.sv
design/scan_timing.sv
design/channel_trace.sv
design/pixel_mixer.sv
design/vga_scope.sv
verification/vga_scope_tb.sv

// ==== Makefile ====
TOP = vga_scope_tb

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vga_scope.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
